// File: all.f
obi_pkg.sv
lsu_pkg.sv
lsu_req_align.sv
obi_master_ctrl.sv
lsu_resp_extract.sv
obi_sram.sv
lsu_obi_top.sv
lsu_obi_asserts.sv
tb_lsu_obi.sv

// File: tb_lsu_obi.sv
// testbench for the load/store path to the OBI SRAM
// drives random loads and stores through lsu_obi_top and checks every
// response against a byte-wide reference memory

`timescale 1ns/100ps
`default_nettype none

module tb_lsu_obi;

    localparam int TIMEOUT   = 50;
    localparam int MEM_BYTES = obi_pkg::MEM_WORDS * 4;

    logic               clk;
    logic               rst_n;
    logic               core_valid;
    obi_pkg::addr_t     core_addr;
    logic               core_we;
    lsu_pkg::lsu_size_t core_size;
    logic               core_unsigned;
    obi_pkg::data_t     core_wdata;
    logic               core_rready;
    logic               req_ready;
    logic               resp_valid;
    obi_pkg::data_t     resp_rdata;
    logic               resp_err;

    // reference memory, one entry per byte
    logic [7:0] model_mem [MEM_BYTES];

    int data_errors;
    int err_errors;
    int proto_errors;

    lsu_obi_top uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .core_valid_i    (core_valid),
        .core_addr_i     (core_addr),
        .core_we_i       (core_we),
        .core_size_i     (core_size),
        .core_unsigned_i (core_unsigned),
        .core_wdata_i    (core_wdata),
        .core_rready_i   (core_rready),
        .req_ready_o     (req_ready),
        .resp_valid_o    (resp_valid),
        .resp_rdata_o    (resp_rdata),
        .resp_err_o      (resp_err)
    );

    bind obi_master_ctrl lsu_obi_asserts u_asserts (
        .clk (clk), .rst_n (rst_n), .obi_req_o (obi_req_o), .obi_gnt_i (obi_gnt_i),
        .obi_addr_o (obi_addr_o), .obi_we_o (obi_we_o), .obi_be_o (obi_be_o),
        .obi_wdata_o (obi_wdata_o), .obi_atop_o (obi_atop_o),
        .resp_valid_o (resp_valid_o), .resp_word_o (resp_word_o),
        .resp_err_o (resp_err_o), .core_rready_i (core_rready_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_data(input string name, input obi_pkg::data_t exp,
                              input obi_pkg::data_t act);
        if (exp !== act) begin
            data_errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            err_errors++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("Test FAILED");
        $finish;
    endtask

    function automatic lsu_pkg::lsu_size_t rand_size();
        case ($urandom % 3)
            0: return lsu_pkg::SIZE_BYTE;
            1: return lsu_pkg::SIZE_HALF;
            default: return lsu_pkg::SIZE_WORD;
        endcase
    endfunction

    // load value from the reference, extended per rv32 rules
    function automatic obi_pkg::data_t model_load(input int a, input lsu_pkg::lsu_size_t size,
                                                  input logic uns);
        logic [15:0] h;
        h = {model_mem[(a + 1) % MEM_BYTES], model_mem[a]};
        if (size == lsu_pkg::SIZE_BYTE) begin
            return uns ? {24'h0, h[7:0]} : {{24{h[7]}}, h[7:0]};
        end else if (size == lsu_pkg::SIZE_HALF) begin
            return uns ? {16'h0, h} : {{16{h[15]}}, h};
        end
        return {model_mem[a + 3], model_mem[a + 2], h};
    endfunction

    // one full access: expected result, request, back-pressure, response
    task automatic do_access(input string name, input logic we, input obi_pkg::addr_t addr,
                             input lsu_pkg::lsu_size_t size, input logic uns,
                             input obi_pkg::data_t wdata, input int hold);
        obi_pkg::data_t exp_data;
        obi_pkg::data_t held_data;
        logic           exp_err;
        int             cnt;
        exp_err = (size == lsu_pkg::SIZE_HALF && addr[0]) ||
                  (size == lsu_pkg::SIZE_WORD && addr[1:0] != 2'd0) || (addr >= MEM_BYTES);
        exp_data = '0;
        if (!exp_err && we) begin
            model_mem[addr] = wdata[7:0];
            if (size != lsu_pkg::SIZE_BYTE) model_mem[addr + 1] = wdata[15:8];
            if (size == lsu_pkg::SIZE_WORD) begin
                model_mem[addr + 2] = wdata[23:16];
                model_mem[addr + 3] = wdata[31:24];
            end
        end else if (!exp_err) begin
            exp_data = model_load(int'(addr), size, uns);
        end
        cnt = 0;
        while (!req_ready) begin
            @(posedge clk);
            #10;
            cnt++;
            if (cnt > TIMEOUT) abort_run({name, ": req_ready_o never rose"});
        end
        core_valid    = 1'b1;
        core_we       = we;
        core_addr     = addr;
        core_size     = size;
        core_unsigned = uns;
        core_wdata    = wdata;
        @(posedge clk);
        #10;
        core_valid = 1'b0;
        cnt = 0;
        while (!resp_valid) begin
            @(posedge clk);
            #10;
            cnt++;
            if (cnt > TIMEOUT) abort_run({name, ": no response after the request"});
        end
        held_data = resp_rdata;
        // core not ready, response must sit still
        repeat (hold) begin
            @(posedge clk);
            #10;
            check_data({name, " held"}, held_data, resp_rdata);
            if (!resp_valid || req_ready) begin
                proto_errors++;
                $display("%s: response dropped or new request allowed under back-pressure", name);
            end
        end
        check_data(name, exp_data, resp_rdata);
        check_err({name, " err"}, exp_err, resp_err);
        core_rready = 1'b1;
        @(posedge clk);
        #10;
        core_rready = 1'b0;
    endtask

    initial begin
        int unsigned    seed_val;
        obi_pkg::addr_t a;
        lsu_pkg::lsu_size_t sz;
        seed_val      = $urandom(32'h1773);
        data_errors   = 0;
        err_errors    = 0;
        proto_errors  = 0;
        rst_n         = 1'b0;
        core_valid    = 1'b0;
        core_addr     = '0;
        core_we       = 1'b0;
        core_size     = lsu_pkg::SIZE_WORD;
        core_unsigned = 1'b0;
        core_wdata    = '0;
        core_rready   = 1'b0;
        for (int i = 0; i < MEM_BYTES; i++) model_mem[i] = 8'h00;
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;
        if (!req_ready || resp_valid) begin
            proto_errors++;
            $display("wrong ready or valid level after reset");
        end
        // word write then read back
        for (int i = 0; i < 16; i++) begin
            a = ($urandom % obi_pkg::MEM_WORDS) * 4;
            do_access("word_wr", 1'b1, a, lsu_pkg::SIZE_WORD, 1'b0, $urandom, 0);
            do_access("word_rd", 1'b0, a, lsu_pkg::SIZE_WORD, 1'b0, '0, 0);
        end
        // partial stores, whole word read shows the merge
        for (int i = 0; i < 16; i++) begin
            a  = $urandom % MEM_BYTES;
            sz = (i % 2) ? lsu_pkg::SIZE_HALF : lsu_pkg::SIZE_BYTE;
            if (sz == lsu_pkg::SIZE_HALF) a[0] = 1'b0;
            do_access("part_wr", 1'b1, a, sz, 1'b0, $urandom, 0);
            do_access("merge_rd", 1'b0, {a[31:2], 2'b00}, lsu_pkg::SIZE_WORD, 1'b0, '0, 0);
        end
        // byte and half loads at every lane, signed and unsigned
        for (int i = 0; i < 8; i++) begin
            a = ($urandom % obi_pkg::MEM_WORDS) * 4;
            // negative bytes on odd rounds, positive on even ones
            do_access("ext_wr", 1'b1, a, lsu_pkg::SIZE_WORD, 1'b0,
                      (i % 2) ? ($urandom | 32'h8080_8080) : ($urandom & 32'h7f7f_7f7f), 0);
            for (int l = 0; l < 4; l++) begin
                do_access("lb", 1'b0, a + l, lsu_pkg::SIZE_BYTE, 1'b0, '0, 0);
                do_access("lbu", 1'b0, a + l, lsu_pkg::SIZE_BYTE, 1'b1, '0, 0);
                if (l % 2 == 0) begin
                    do_access("lh", 1'b0, a + l, lsu_pkg::SIZE_HALF, 1'b0, '0, 0);
                    do_access("lhu", 1'b0, a + l, lsu_pkg::SIZE_HALF, 1'b1, '0, 0);
                end
            end
        end
        // misaligned and out of range, then read back what is behind them
        for (int i = 0; i < 8; i++) begin
            a = ($urandom % obi_pkg::MEM_WORDS) * 4;
            do_access("mis_sh", 1'b1, a + 1, lsu_pkg::SIZE_HALF, 1'b0, $urandom, 0);
            do_access("mis_sw", 1'b1, a + 1 + (i % 3), lsu_pkg::SIZE_WORD, 1'b0, $urandom, 0);
            do_access("mis_lw", 1'b0, a + 3, lsu_pkg::SIZE_WORD, 1'b0, '0, 0);
            do_access("mis_chk", 1'b0, a, lsu_pkg::SIZE_WORD, 1'b0, '0, 0);
            // low address bits alias word a
            do_access("oor_sw", 1'b1, a | 32'h400 | ($urandom & 32'hFFFF_F800),
                      lsu_pkg::SIZE_WORD, 1'b0, $urandom, 0);
            do_access("oor_chk", 1'b0, a, lsu_pkg::SIZE_WORD, 1'b0, '0, 0);
        end
        // back-pressure on the held response
        for (int i = 0; i < 8; i++) begin
            a = ($urandom % obi_pkg::MEM_WORDS) * 4;
            do_access("bp_rd", 1'b0, a, lsu_pkg::SIZE_WORD, 1'b0, '0, 1 + $urandom % 8);
        end
        // random mix, mostly aligned, a few past the end
        for (int i = 0; i < 400; i++) begin
            sz = rand_size();
            a  = ($urandom % 16 == 0) ? ($urandom | 32'h400) : ($urandom % MEM_BYTES);
            if ($urandom % 4 != 0) begin
                if (sz == lsu_pkg::SIZE_HALF) a[0] = 1'b0;
                if (sz == lsu_pkg::SIZE_WORD) a[1:0] = 2'b00;
            end
            repeat ($urandom % 3) begin
                @(posedge clk);
                #10;
            end
            do_access("mix", $urandom % 2, a, sz, $urandom % 2, $urandom, $urandom % 4);
        end
        $display("errors: data %0d, err flag %0d, protocol %0d",
                 data_errors, err_errors, proto_errors);
        if (data_errors + err_errors + proto_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: lsu_obi_asserts.sv
// protocol checks for the OBI master controller
// address phase stability, no bus request while a response is held,
// held response stability under back-pressure, atop tied to zero

`timescale 1ns/100ps
`default_nettype none

module lsu_obi_asserts (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           obi_req_o,
    input  logic           obi_gnt_i,
    input  obi_pkg::addr_t obi_addr_o,
    input  logic           obi_we_o,
    input  obi_pkg::be_t   obi_be_o,
    input  obi_pkg::data_t obi_wdata_o,
    input  obi_pkg::atop_t obi_atop_o,
    input  logic           resp_valid_o,
    input  obi_pkg::data_t resp_word_o,
    input  logic           resp_err_o,
    input  logic           core_rready_i
);

    // address phase frozen until granted
    req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        obi_req_o && !obi_gnt_i |=> obi_req_o && $stable(obi_addr_o) && $stable(obi_we_o)
            && $stable(obi_be_o) && $stable(obi_wdata_o))
        else $error("obi address phase changed before grant");

    // one transaction at a time
    no_req_in_dump_a: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_o |-> !obi_req_o)
        else $error("obi_req raised while a response is held");

    // held response under back-pressure
    resp_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_o && !core_rready_i |=> resp_valid_o && $stable(resp_word_o)
            && $stable(resp_err_o))
        else $error("held response changed while core_rready low");

    atop_zero_a: assert property (@(posedge clk) disable iff (!rst_n)
        obi_atop_o == '0)
        else $error("obi_atop not zero");

endmodule

`default_nettype wire

// File: lsu_obi_top.sv
// load/store path top level
// request alignment, OBI master controller, load extraction and the
// on-chip SRAM slave wired together

`timescale 1ns/100ps
`default_nettype none

module lsu_obi_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               core_valid_i,
    input  obi_pkg::addr_t     core_addr_i,
    input  logic               core_we_i,
    input  lsu_pkg::lsu_size_t core_size_i,
    input  logic               core_unsigned_i,
    input  obi_pkg::data_t     core_wdata_i,
    input  logic               core_rready_i,
    output logic               req_ready_o,
    output logic               resp_valid_o,
    output obi_pkg::data_t     resp_rdata_o,
    output logic               resp_err_o
);

    // align to controller
    obi_pkg::be_t       be;
    obi_pkg::data_t     wdata_aligned;
    logic               misaligned;

    // OBI bus
    logic               obi_req;
    logic               obi_gnt;
    obi_pkg::addr_t     obi_addr;
    logic               obi_we;
    obi_pkg::be_t       obi_be;
    obi_pkg::data_t     obi_wdata;
    obi_pkg::data_t     obi_rdata;
    logic               obi_rvalid;
    logic               obi_err;

    // controller to extract
    obi_pkg::data_t     resp_word;
    lsu_pkg::lane_t     resp_lane;
    lsu_pkg::lsu_size_t resp_size;
    logic               resp_unsigned;

    lsu_req_align u_align (
        .addr_i       (core_addr_i),
        .size_i       (core_size_i),
        .wdata_i      (core_wdata_i),
        .be_o         (be),
        .wdata_o      (wdata_aligned),
        .misaligned_o (misaligned)
    );

    obi_master_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .core_valid_i    (core_valid_i),
        .core_rready_i   (core_rready_i),
        .core_addr_i     (core_addr_i),
        .core_we_i       (core_we_i),
        .core_size_i     (core_size_i),
        .core_unsigned_i (core_unsigned_i),
        .be_i            (be),
        .wdata_i         (wdata_aligned),
        .misaligned_i    (misaligned),
        .req_ready_o     (req_ready_o),
        .obi_req_o       (obi_req),
        .obi_gnt_i       (obi_gnt),
        .obi_addr_o      (obi_addr),
        .obi_we_o        (obi_we),
        .obi_be_o        (obi_be),
        .obi_wdata_o     (obi_wdata),
        // sram has no atomics, atop checked at the controller
        .obi_atop_o      (),
        .obi_rdata_i     (obi_rdata),
        .obi_rvalid_i    (obi_rvalid),
        .obi_err_i       (obi_err),
        .resp_valid_o    (resp_valid_o),
        .resp_word_o     (resp_word),
        .resp_err_o      (resp_err_o),
        .resp_lane_o     (resp_lane),
        .resp_size_o     (resp_size),
        .resp_unsigned_o (resp_unsigned)
    );

    lsu_resp_extract u_extract (
        .word_i     (resp_word),
        .lane_i     (resp_lane),
        .size_i     (resp_size),
        .unsigned_i (resp_unsigned),
        .rdata_o    (resp_rdata_o)
    );

    obi_sram u_sram (
        .clk          (clk),
        .rst_n        (rst_n),
        .obi_req_i    (obi_req),
        .obi_addr_i   (obi_addr),
        .obi_we_i     (obi_we),
        .obi_be_i     (obi_be),
        .obi_wdata_i  (obi_wdata),
        .obi_gnt_o    (obi_gnt),
        .obi_rdata_o  (obi_rdata),
        .obi_rvalid_o (obi_rvalid),
        .obi_err_o    (obi_err)
    );

endmodule

`default_nettype wire

// File: obi_sram.sv
// OBI slave SRAM
// word memory of MEM_WORDS entries with byte-enable writes.
// an 8-bit LFSR stalls the grant for up to three cycles in a row,
// rvalid follows one cycle after the grant. addresses past the end
// of the array write nothing and answer with an error

`timescale 1ns/100ps
`default_nettype none

module obi_sram (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           obi_req_i,
    input  obi_pkg::addr_t obi_addr_i,
    input  logic           obi_we_i,
    input  obi_pkg::be_t   obi_be_i,
    input  obi_pkg::data_t obi_wdata_i,
    output logic           obi_gnt_o,
    output obi_pkg::data_t obi_rdata_o,
    output logic           obi_rvalid_o,
    output logic           obi_err_o
);

    obi_pkg::data_t    mem_q [obi_pkg::MEM_WORDS];
    obi_pkg::mem_idx_t idx;

    logic [7:0] lfsr_q;
    // consecutive stall cycles of the pending request
    logic [1:0] stall_cnt_q;
    logic       stall;
    logic       in_range;

    assign idx      = obi_addr_i[obi_pkg::MEM_AW+1:2];
    // upper address bits must be zero
    assign in_range = (obi_addr_i[obi_pkg::ADDR_W-1:obi_pkg::MEM_AW+2] == '0);

    // stall on lfsr bit, never a fourth time
    assign stall     = lfsr_q[0] & (stall_cnt_q != 2'd3);
    assign obi_gnt_o = obi_req_i & ~stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q      <= 8'hA5;
            stall_cnt_q <= 2'd0;
        end else begin
            // galois form, x^8 + x^6 + x^5 + x^4 + 1
            lfsr_q <= {1'b0, lfsr_q[7:1]} ^ (lfsr_q[0] ? 8'hB8 : 8'h00);
            if (obi_gnt_o) begin
                stall_cnt_q <= 2'd0;
            end else if (obi_req_i) begin
                stall_cnt_q <= stall_cnt_q + 2'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < obi_pkg::MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (obi_gnt_o && obi_we_i && in_range) begin
            // enabled bytes only
            for (int b = 0; b < obi_pkg::BE_W; b++) begin
                if (obi_be_i[b]) begin
                    mem_q[idx][8*b +: 8] <= obi_wdata_i[8*b +: 8];
                end
            end
        end
    end

    // response phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            obi_rvalid_o <= 1'b0;
            obi_err_o    <= 1'b0;
        end else begin
            obi_rvalid_o <= obi_gnt_o;
            if (obi_gnt_o) begin
                obi_err_o <= ~in_range;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (obi_gnt_o) begin
            // zero for writes and out-of-range reads
            obi_rdata_o <= (in_range && !obi_we_i) ? mem_q[idx] : '0;
        end
    end

endmodule

`default_nettype wire

// File: lsu_resp_extract.sv
// load response extraction
// picks the addressed byte or half out of the held read word and
// sign- or zero-extends it to a full register value

`timescale 1ns/100ps
`default_nettype none

module lsu_resp_extract (
    input  obi_pkg::data_t     word_i,
    input  lsu_pkg::lane_t     lane_i,
    input  lsu_pkg::lsu_size_t size_i,
    input  logic               unsigned_i,
    output obi_pkg::data_t     rdata_o
);

    // word moved down so the addressed byte sits in lane 0
    obi_pkg::data_t shifted;
    logic           sign_b;
    logic           sign_h;

    // lane times eight
    assign shifted = word_i >> {lane_i, 3'b000};

    // extension bits, zero for unsigned loads
    assign sign_b = ~unsigned_i & shifted[7];
    assign sign_h = ~unsigned_i & shifted[15];

    always_comb begin
        case (size_i)
            lsu_pkg::SIZE_BYTE: begin
                rdata_o = {{24{sign_b}}, shifted[7:0]};
            end
            lsu_pkg::SIZE_HALF: begin
                rdata_o = {{16{sign_h}}, shifted[15:0]};
            end
            lsu_pkg::SIZE_WORD: begin
                // lane is zero for any word that got to the bus
                rdata_o = shifted;
            end
            default: begin
                rdata_o = shifted;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: obi_master_ctrl.sv
// OBI master controller
// takes one core request at a time, drives the OBI address phase until
// the grant, waits for rvalid and holds the response until the core
// reads it. misaligned requests are answered with an error and never
// reach the bus. no outstanding transactions, no atomics

`timescale 1ns/100ps
`default_nettype none

module obi_master_ctrl (
    input  logic               clk,
    input  logic               rst_n,

    // core request
    input  logic               core_valid_i,
    input  logic               core_rready_i,
    input  obi_pkg::addr_t     core_addr_i,
    input  logic               core_we_i,
    input  lsu_pkg::lsu_size_t core_size_i,
    input  logic               core_unsigned_i,
    input  obi_pkg::be_t       be_i,
    input  obi_pkg::data_t     wdata_i,
    input  logic               misaligned_i,
    output logic               req_ready_o,

    // OBI master side
    output logic               obi_req_o,
    input  logic               obi_gnt_i,
    output obi_pkg::addr_t     obi_addr_o,
    output logic               obi_we_o,
    output obi_pkg::be_t       obi_be_o,
    output obi_pkg::data_t     obi_wdata_o,
    output obi_pkg::atop_t     obi_atop_o,
    input  obi_pkg::data_t     obi_rdata_i,
    input  logic               obi_rvalid_i,
    input  logic               obi_err_i,

    // held response
    output logic               resp_valid_o,
    output obi_pkg::data_t     resp_word_o,
    output logic               resp_err_o,
    output lsu_pkg::lane_t     resp_lane_o,
    output lsu_pkg::lsu_size_t resp_size_o,
    output logic               resp_unsigned_o
);

    obi_pkg::obi_state_t state_q;
    obi_pkg::obi_state_t state_d;

    // captured request, used from REQUESTING on
    obi_pkg::addr_t     addr_q;
    logic               we_q;
    obi_pkg::be_t       be_q;
    obi_pkg::data_t     wdata_q;
    lsu_pkg::lane_t     lane_q;
    lsu_pkg::lsu_size_t size_q;
    logic               unsigned_q;

    // response held for the core
    obi_pkg::data_t     rsp_word_q;
    logic               rsp_err_q;

    logic               accept;

    // only idle takes a new request
    assign req_ready_o = (state_q == obi_pkg::IDLE);
    assign accept      = core_valid_i & req_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            obi_pkg::IDLE: begin
                if (accept) begin
                    // misaligned skips the bus entirely
                    if (misaligned_i) begin
                        state_d = obi_pkg::DUMPING;
                    end else if (obi_gnt_i) begin
                        state_d = obi_pkg::WAITING;
                    end else begin
                        state_d = obi_pkg::REQUESTING;
                    end
                end
            end
            obi_pkg::REQUESTING: begin
                if (obi_gnt_i) begin
                    state_d = obi_pkg::WAITING;
                end
            end
            obi_pkg::WAITING: begin
                if (obi_rvalid_i) begin
                    state_d = obi_pkg::DUMPING;
                end
            end
            obi_pkg::DUMPING: begin
                if (core_rready_i) begin
                    state_d = obi_pkg::IDLE;
                end
            end
            default: state_d = obi_pkg::IDLE;
        endcase
    end

    // address phase mux
    always_comb begin
        if (state_q == obi_pkg::IDLE) begin
            // live request so obi_req rises in the accept cycle
            obi_req_o   = core_valid_i & ~misaligned_i;
            obi_addr_o  = {core_addr_i[obi_pkg::ADDR_W-1:2], 2'b00};
            obi_we_o    = core_we_i;
            obi_be_o    = be_i;
            obi_wdata_o = wdata_i;
        end else begin
            // captured copy held stable until the grant
            obi_req_o   = (state_q == obi_pkg::REQUESTING);
            obi_addr_o  = addr_q;
            obi_we_o    = we_q;
            obi_be_o    = be_q;
            obi_wdata_o = wdata_q;
        end
    end

    // atomics not supported
    assign obi_atop_o = '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= obi_pkg::IDLE;
            rsp_err_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept && misaligned_i) begin
                rsp_err_q <= 1'b1;
            end else if ((state_q == obi_pkg::WAITING) && obi_rvalid_i) begin
                rsp_err_q <= obi_err_i;
            end
        end
    end

    // request capture on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q     <= {core_addr_i[obi_pkg::ADDR_W-1:2], 2'b00};
            we_q       <= core_we_i;
            be_q       <= be_i;
            wdata_q    <= wdata_i;
            lane_q     <= core_addr_i[1:0];
            size_q     <= core_size_i;
            unsigned_q <= core_unsigned_i;
        end
    end

    // response word, zero for writes and errors without bus access
    always_ff @(posedge clk) begin
        if (accept && misaligned_i) begin
            rsp_word_q <= '0;
        end else if ((state_q == obi_pkg::WAITING) && obi_rvalid_i) begin
            rsp_word_q <= we_q ? '0 : obi_rdata_i;
        end
    end

    assign resp_valid_o    = (state_q == obi_pkg::DUMPING);
    assign resp_word_o     = rsp_word_q;
    assign resp_err_o      = rsp_err_q;
    assign resp_lane_o     = lane_q;
    assign resp_size_o     = size_q;
    assign resp_unsigned_o = unsigned_q;

endmodule

`default_nettype wire

// File: lsu_req_align.sv
// load/store request alignment
// turns the core's address offset and access size into OBI byte enables,
// puts the store data onto the addressed lanes and flags misaligned
// half and word accesses. purely combinational

`timescale 1ns/100ps
`default_nettype none

module lsu_req_align (
    input  obi_pkg::addr_t     addr_i,
    input  lsu_pkg::lsu_size_t size_i,
    input  obi_pkg::data_t     wdata_i,
    output obi_pkg::be_t       be_o,
    output obi_pkg::data_t     wdata_o,
    output logic               misaligned_o
);

    // offset of the access inside the word
    lsu_pkg::lane_t lane;

    assign lane = addr_i[1:0];

    always_comb begin
        // defaults for the word case
        be_o         = 4'b1111;
        wdata_o      = wdata_i;
        misaligned_o = 1'b0;

        case (size_i)
            lsu_pkg::SIZE_BYTE: begin
                // single lane
                be_o    = 4'b0001 << lane;
                // byte copied to every lane, be picks the right one
                wdata_o = {4{wdata_i[7:0]}};
            end

            lsu_pkg::SIZE_HALF: begin
                // two adjacent lanes
                be_o    = 4'b0011 << lane;
                wdata_o = {2{wdata_i[15:0]}};
                // half must start on an even byte
                misaligned_o = lane[0];
            end

            lsu_pkg::SIZE_WORD: begin
                be_o    = 4'b1111;
                wdata_o = wdata_i;
                // word only at offset zero
                misaligned_o = (lane != 2'd0);
            end

            default: begin
                // unused size code, treated like a word
                be_o         = 4'b1111;
                wdata_o      = wdata_i;
                misaligned_o = (lane != 2'd0);
            end
        endcase
    end

endmodule

`default_nettype wire

// File: lsu_pkg.sv
// load/store unit package
// core-side access size encoding and byte lane type

`default_nettype none

package lsu_pkg;

    // width of the byte offset inside a word
    localparam int LANE_W = 2;

    // access size as given by the core
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } lsu_size_t;

    // byte offset of the access inside the word
    typedef logic [LANE_W-1:0] lane_t;

endpackage

`default_nettype wire

// File: obi_pkg.sv
// OBI bus package
// widths, vector types, SRAM sizing and the master controller states
// for the load/store path between the core and the on-chip memory

`default_nettype none

package obi_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;
    localparam int ATOP_W = 6;

    // sram depth in words
    localparam int MEM_WORDS = 256;
    // word index bits
    localparam int MEM_AW    = $clog2(MEM_WORDS);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [BE_W-1:0]   be_t;
    typedef logic [ATOP_W-1:0] atop_t;
    // word index into the sram array
    typedef logic [MEM_AW-1:0] mem_idx_t;

    // one state per bus phase
    typedef enum logic [1:0] {
        IDLE,
        REQUESTING,
        WAITING,
        DUMPING
    } obi_state_t;

endpackage

`default_nettype wire
